/* sources.f */
verilog/mini_core_accel_pkg.sv
verilog/mini_core_accel_cr_arb.sv
verilog/mini_core_accel_cr_mem.sv
verilog/mini_core_accel_mul_farm.sv
verilog/mini_core_accel_top.sv
verification/mini_core_accel_properties.sv
verification/tb_clock_gen.sv
verification/mini_core_accel_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
    --top-module mini_core_accel_tb \
    -f sources.f \
    -o mini_core_accel_sim

# A stopped or failing run still prints its output before the search
sim_out="$(./obj_dir/mini_core_accel_sim || true)"
echo "$sim_out"

grep -qx "TEST PASSED" <<< "$sim_out"

/* verification/mini_core_accel_tb.sv */
// Needs timing support and enabled assertions; operands come from a fixed $urandom seed
`timescale 1ns/10ps
`default_nettype none

module mini_core_accel_tb
    import mini_core_accel_pkg::*;
();

localparam logic [31:0] RANDOM_SEED = 32'h9c2d2822;
localparam int WAIT_LIMIT  = 64;
localparam int POLL_LIMIT  = 16;
localparam int BURST_LEN   = 6;
localparam int WATCHDOG_NS = 100000;

logic        Clk;
logic        rst_n;
logic        req_valid     [NUM_PORTS];
logic        req_write     [NUM_PORTS];
logic [31:0] req_addr      [NUM_PORTS];
logic [31:0] req_wdata     [NUM_PORTS];
logic        credit_return [NUM_PORTS];
logic        rsp_valid     [NUM_PORTS];
logic [31:0] rsp_rdata     [NUM_PORTS];

int          credits [NUM_PORTS];
logic [31:0] rsp_q   [NUM_PORTS][$];
logic [7:0]  op_a    [NUM_MULS];
logic [7:0]  op_b    [NUM_MULS];
int          errors;
int          checks;
int          tests_run;

tb_clock_gen clock_gen_i (
    .Clk   (Clk),
    .rst_n (rst_n)
);

mini_core_accel_top dut_i (
    .Clk           (Clk),
    .rst_n         (rst_n),
    .req_valid     (req_valid),
    .req_write     (req_write),
    .req_addr      (req_addr),
    .req_wdata     (req_wdata),
    .credit_return (credit_return),
    .rsp_valid     (rsp_valid),
    .rsp_rdata     (rsp_rdata)
);

// --------------------------------------------------
// Credit counters and response collection
// --------------------------------------------------
always @(posedge Clk) begin
    for (int p = 0; p < NUM_PORTS; p++) begin
        if (!rst_n) begin
            credits[p] <= NUM_CREDITS;
        end else begin
            credits[p] <= credits[p] - int'(req_valid[p]) + int'(credit_return[p]);
        end
        if (rsp_valid[p]) begin
            rsp_q[p].push_back(rsp_rdata[p]);
        end
    end
end

function automatic logic [31:0] op_addr(input int i);
    return CR_CORE2MUL_BASE + 32'(i * 4);
endfunction

function automatic logic [31:0] st_addr(input int i);
    return CR_MUL2CORE_BASE + 32'(i * 4);
endfunction

// Status word is 15 zero bits, done, then the unsigned product
function automatic logic [31:0] expected_status(input logic done, input logic [7:0] a,
                                                input logic [7:0] b);
    return {15'b0, done, {8'b0, a} * {8'b0, b}};
endfunction

function automatic int burst_unit(input int p, input int k);
    return (k * 3 + p * 5) % NUM_MULS;
endfunction

task automatic check_word(input logic [31:0] got, input logic [31:0] exp, input string what);
    checks++;
    assert (got === exp) else begin
        $display("CHECK FAILED at %0t ns: %s, got %h, expected %h", $time, what, got, exp);
        errors++;
    end
endtask

task automatic end_test(input string name, input int mark);
    tests_run++;
    if (errors == mark) begin
        $display("%s: pass", name);
    end else begin
        $display("%s: %0d errors", name, errors - mark);
    end
endtask

task automatic wait_reset();
    int waited;
    waited = 0;
    while (rst_n !== 1'b1) begin
        if (waited == WAIT_LIMIT) begin
            $display("Timeout at %0t ns: reset was never released", $time);
            errors++;
            return;
        end
        waited++;
        @(posedge Clk);
    end
endtask

// --------------------------------------------------
// Port access
// --------------------------------------------------
// Credit is usable if the last cycle's send is counted and any returned one added
task automatic send_req(input int p, input logic is_write, input logic [31:0] addr,
                        input logic [31:0] wdata);
    int waited;
    waited = 0;
    @(posedge Clk);
    while (credits[p] - int'(req_valid[p]) + int'(credit_return[p]) <= 0) begin
        req_valid[p] <= 1'b0;
        if (waited == WAIT_LIMIT) begin
            $display("Timeout at %0t ns: port %0d never got a credit back", $time, p);
            errors++;
            return;
        end
        waited++;
        @(posedge Clk);
    end
    req_valid[p] <= 1'b1;
    req_write[p] <= is_write;
    req_addr[p]  <= addr;
    req_wdata[p] <= wdata;
endtask

task automatic release_port(input int p);
    @(posedge Clk);
    req_valid[p] <= 1'b0;
endtask

task automatic wait_rsp(input int p, output logic [31:0] data);
    int waited;
    waited = 0;
    data   = '0;
    while (rsp_q[p].size() == 0) begin
        if (waited == WAIT_LIMIT) begin
            $display("Timeout at %0t ns: port %0d got no read response", $time, p);
            errors++;
            return;
        end
        waited++;
        @(posedge Clk);
    end
    data = rsp_q[p].pop_front();
endtask

task automatic write_word(input int p, input logic [31:0] addr, input logic [31:0] wdata);
    send_req(p, 1'b1, addr, wdata);
    release_port(p);
endtask

task automatic read_word(input int p, input logic [31:0] addr, output logic [31:0] data);
    send_req(p, 1'b0, addr, '0);
    release_port(p);
    wait_rsp(p, data);
endtask

// Polls until done, then checks the whole word
task automatic poll_status(input int p, input int unit, input logic [31:0] exp,
                           input string what);
    logic [31:0] data;
    int          polls;
    polls = 0;
    read_word(p, st_addr(unit), data);
    while (!data[16]) begin
        if (polls == POLL_LIMIT) begin
            $display("Timeout at %0t ns: %s, unit %0d never finished", $time, what, unit);
            errors++;
            return;
        end
        polls++;
        read_word(p, st_addr(unit), data);
    end
    check_word(data, exp, what);
endtask

// --------------------------------------------------
// Tests
// --------------------------------------------------
task automatic check_reset_state();
    int          mark;
    logic [31:0] data;
    mark = errors;
    repeat (3) begin
        @(posedge Clk);
        for (int p = 0; p < NUM_PORTS; p++) begin
            check_word(32'(rsp_valid[p]), '0, $sformatf("port %0d rsp_valid idle", p));
            check_word(32'(credit_return[p]), '0, $sformatf("port %0d credit idle", p));
        end
    end
    for (int i = 0; i < NUM_MULS; i++) begin
        read_word(i % NUM_PORTS, st_addr(i), data);
        check_word(data, '0, $sformatf("status %0d after reset", i));
    end
    end_test("reset", mark);
endtask

task automatic multiply_one_unit();
    int mark;
    int unit;
    mark = errors;
    unit = int'($urandom % NUM_MULS);
    op_a[unit] = 8'($urandom);
    op_b[unit] = 8'($urandom);
    write_word(0, op_addr(unit), {16'($urandom), op_a[unit], op_b[unit]});
    poll_status(0, unit, expected_status(1'b1, op_a[unit], op_b[unit]), "single multiply");
    end_test("single multiply", mark);
endtask

task automatic multiply_all_units();
    int          mark;
    logic [31:0] data;
    mark = errors;
    for (int i = 0; i < NUM_MULS; i++) begin
        op_a[i] = 8'($urandom);
        op_b[i] = 8'($urandom);
        send_req(0, 1'b1, op_addr(i), {16'($urandom), op_a[i], op_b[i]});
    end
    release_port(0);
    for (int i = 0; i < NUM_MULS; i++) begin
        read_word(i % NUM_PORTS, st_addr(i), data);
        check_word(data, expected_status(1'b1, op_a[i], op_b[i]),
                   $sformatf("unit %0d product", i));
    end
    end_test("all units", mark);
endtask

// Two writes back to back, the second lands while the unit is busy
// First poll comes after done has cleared, so a stale done shows the old product
task automatic restart_unit();
    int mark;
    int unit;
    mark = errors;
    unit = int'($urandom % NUM_MULS);
    for (int n = 0; n < 2; n++) begin
        op_a[unit] = 8'($urandom);
        op_b[unit] = 8'($urandom);
        send_req(0, 1'b1, op_addr(unit), {16'($urandom), op_a[unit], op_b[unit]});
    end
    release_port(0);
    poll_status(0, unit, expected_status(1'b1, op_a[unit], op_b[unit]), "restarted unit");
    end_test("restart", mark);
endtask

// Third read of each burst goes to an unmapped address
task automatic issue_burst(input int p);
    for (int k = 0; k < BURST_LEN; k++) begin
        if (k == 2) begin
            send_req(p, 1'b0, 32'h0000_0080, '0);
        end else begin
            send_req(p, 1'b0, st_addr(burst_unit(p, k)), '0);
        end
    end
    release_port(p);
endtask

task automatic contend_both_ports();
    int          mark;
    int          unit;
    logic [31:0] data;
    mark = errors;
    fork
        issue_burst(0);
        issue_burst(1);
    join
    for (int p = 0; p < NUM_PORTS; p++) begin
        for (int k = 0; k < BURST_LEN; k++) begin
            unit = burst_unit(p, k);
            wait_rsp(p, data);
            check_word(data, (k == 2) ? '0 : expected_status(1'b1, op_a[unit], op_b[unit]),
                       $sformatf("port %0d burst read %0d", p, k));
        end
    end
    end_test("contention", mark);
endtask

task automatic read_unmapped();
    int          mark;
    logic [31:0] addrs [4];
    logic [31:0] data;
    mark  = errors;
    // Operand register, past the status bank, misaligned status, far region
    addrs = '{op_addr(3), 32'h0000_0100, CR_MUL2CORE_BASE + 32'h2, 32'hFFFF_FFC0};
    for (int n = 0; n < 4; n++) begin
        read_word(n % NUM_PORTS, addrs[n], data);
        check_word(data, '0, $sformatf("read of %h", addrs[n]));
    end
    end_test("unmapped", mark);
endtask

// --------------------------------------------------
// Main sequence
// --------------------------------------------------
initial begin
    void'($urandom(RANDOM_SEED));
    errors    = 0;
    checks    = 0;
    tests_run = 0;
    for (int p = 0; p < NUM_PORTS; p++) begin
        req_valid[p] = 1'b0;
        req_write[p] = 1'b0;
        req_addr[p]  = '0;
        req_wdata[p] = '0;
    end
    wait_reset();
    check_reset_state();
    multiply_one_unit();
    multiply_all_units();
    restart_unit();
    contend_both_ports();
    read_unmapped();
    $display("Tests: %0d, checks: %0d, errors: %0d", tests_run, checks, errors);
    if (errors == 0) begin
        $display("TEST PASSED");
    end else begin
        $display("TEST FAILED");
    end
    $finish;
end

initial begin
    #(WATCHDOG_NS);
    $display("Simulation ran past %0d ns without finishing", WATCHDOG_NS);
    $display("TEST FAILED");
    $finish;
end

endmodule

bind mini_core_accel_top mini_core_accel_properties props_i (
    .Clk           (Clk),
    .rst_n         (rst_n),
    .req_valid     (req_valid),
    .req_write     (req_write),
    .req_addr      (req_addr),
    .credit_return (credit_return),
    .rsp_valid     (rsp_valid),
    .cr_wren       (cr_wren),
    .cr_rden       (cr_rden),
    .cr_addr       (cr_addr),
    .mul_start     (mul_start),
    .mul_done      (mul_done)
);

`default_nettype wire

/* verification/tb_clock_gen.sv */
// Clock starts low at time zero; rst_n is held low over the first two rising edges only
`timescale 1ns/10ps
`default_nettype none

module tb_clock_gen (
    output logic Clk,
    output logic rst_n
);

localparam int HALF_PERIOD_NS = 2;
localparam int RESET_CYCLES   = 2;

// 4 ns period
initial begin
    Clk = 1'b0;
    forever #(HALF_PERIOD_NS) Clk = ~Clk;
end

initial begin
    rst_n = 1'b0;
    repeat (RESET_CYCLES) @(posedge Clk);
    rst_n <= 1'b1;
end

endmodule

`default_nettype wire

/* verification/mini_core_accel_properties.sv */
// Assumes the master never sends without a credit; checks protocol only, not data values
`timescale 1ns/10ps
`default_nettype none

module mini_core_accel_properties
    import mini_core_accel_pkg::*;
(
    input logic        Clk,
    input logic        rst_n,
    input logic        req_valid     [NUM_PORTS],
    input logic        req_write     [NUM_PORTS],
    input logic [31:0] req_addr      [NUM_PORTS],
    input logic        credit_return [NUM_PORTS],
    input logic        rsp_valid     [NUM_PORTS],
    input logic        cr_wren,
    input logic        cr_rden,
    input logic [31:0] cr_addr,
    input logic        mul_start     [NUM_MULS],
    input logic        mul_done      [NUM_MULS]
);

// Requests held in the arbiter, and reads still waiting for rsp_valid
int          in_queue  [NUM_PORTS];
int          reads_out [NUM_PORTS];
logic        grant_ok  [NUM_PORTS];
logic [32:0] req_q     [NUM_PORTS][$];

always @(posedge Clk) begin
    for (int p = 0; p < NUM_PORTS; p++) begin
        if (!rst_n) begin
            in_queue[p]  <= 0;
            reads_out[p] <= 0;
            grant_ok[p]  <= 1'b1;
            req_q[p].delete();
        end else begin
            in_queue[p]  <= in_queue[p] + int'(req_valid[p]) - int'(credit_return[p]);
            reads_out[p] <= reads_out[p] + int'(req_valid[p] && !req_write[p])
                                         - int'(rsp_valid[p]);
            grant_ok[p]  <= 1'b1;
            // Granted access must be the oldest request of that port, as a read or a write
            if (credit_return[p]) begin
                grant_ok[p] <= (req_q[p].size() != 0)
                               && (req_q[p][0][32] == cr_wren)
                               && (req_q[p][0][32] != cr_rden)
                               && (req_q[p][0][31:0] == cr_addr);
                if (req_q[p].size() != 0) begin
                    void'(req_q[p].pop_front());
                end
            end
            if (req_valid[p]) begin
                req_q[p].push_back({req_write[p], req_addr[p]});
            end
        end
    end
end

// --------------------------------------------------
// Credits and responses
// --------------------------------------------------
for (genvar p = 0; p < NUM_PORTS; p++) begin : g_port
    a_credit_bound: assert property (@(posedge Clk) disable iff (!rst_n)
        in_queue[p] <= NUM_CREDITS)
        else $error("port %0d holds more than %0d queued requests", p, NUM_CREDITS);
    a_credit_source: assert property (@(posedge Clk) disable iff (!rst_n)
        credit_return[p] |-> in_queue[p] > 0)
        else $error("port %0d got a credit back with an empty queue", p);
    a_rsp_has_read: assert property (@(posedge Clk) disable iff (!rst_n)
        rsp_valid[p] |-> reads_out[p] > 0)
        else $error("port %0d got a response with no read outstanding", p);
    a_grant_order: assert property (@(posedge Clk) disable iff (!rst_n) grant_ok[p])
        else $error("port %0d granted an access that is not its oldest request", p);
end

// --------------------------------------------------
// Multiplier timing
// --------------------------------------------------
for (genvar i = 0; i < NUM_MULS; i++) begin : g_mul
    a_start_clears: assert property (@(posedge Clk) disable iff (!rst_n)
        mul_start[i] |=> !mul_done[i])
        else $error("unit %0d kept done after a new start", i);
    // A restart one cycle later may hold done low
    a_done_latency: assert property (@(posedge Clk) disable iff (!rst_n)
        mul_start[i] |-> ##MUL_LATENCY (mul_done[i] || $past(mul_start[i])))
        else $error("unit %0d missed done %0d cycles after start", i, MUL_LATENCY);
end

endmodule

`default_nettype wire

/* verilog/mini_core_accel_top.sv */
// Masters track their own credits, NUM_CREDITS each after reset; reads answer in port order
`timescale 1ns/10ps
`default_nettype none

module mini_core_accel_top
    import mini_core_accel_pkg::*;
(
    input  logic        Clk,
    input  logic        rst_n,

    // Peer masters
    input  logic        req_valid     [NUM_PORTS],
    input  logic        req_write     [NUM_PORTS],
    input  logic [31:0] req_addr      [NUM_PORTS],
    input  logic [31:0] req_wdata     [NUM_PORTS],
    output logic        credit_return [NUM_PORTS],
    output logic        rsp_valid     [NUM_PORTS],
    output logic [31:0] rsp_rdata     [NUM_PORTS]
);

// CR access path
logic        cr_wren;
logic        cr_rden;
logic [31:0] cr_addr;
logic [31:0] cr_wdata;
logic [31:0] cr_q;

// Farm connections
logic        mul_start        [NUM_MULS];
logic [7:0]  mul_multiplicand [NUM_MULS];
logic [7:0]  mul_multiplier   [NUM_MULS];
logic        mul_done         [NUM_MULS];
logic [15:0] mul_result       [NUM_MULS];

mini_core_accel_cr_arb cr_arb_i (
    .Clk           (Clk),
    .rst_n         (rst_n),
    .req_valid     (req_valid),
    .req_write     (req_write),
    .req_addr      (req_addr),
    .req_wdata     (req_wdata),
    .credit_return (credit_return),
    .rsp_valid     (rsp_valid),
    .rsp_rdata     (rsp_rdata),
    .cr_wren       (cr_wren),
    .cr_rden       (cr_rden),
    .cr_addr       (cr_addr),
    .cr_wdata      (cr_wdata),
    .cr_q          (cr_q)
);

mini_core_accel_cr_mem cr_mem_i (
    .Clk              (Clk),
    .rst_n            (rst_n),
    .cr_wren          (cr_wren),
    .cr_rden          (cr_rden),
    .cr_addr          (cr_addr),
    .cr_wdata         (cr_wdata),
    .cr_q             (cr_q),
    .mul_done         (mul_done),
    .mul_result       (mul_result),
    .mul_start        (mul_start),
    .mul_multiplicand (mul_multiplicand),
    .mul_multiplier   (mul_multiplier)
);

mini_core_accel_mul_farm mul_farm_i (
    .Clk              (Clk),
    .rst_n            (rst_n),
    .mul_start        (mul_start),
    .mul_multiplicand (mul_multiplicand),
    .mul_multiplier   (mul_multiplier),
    .mul_done         (mul_done),
    .mul_result       (mul_result)
);

endmodule

`default_nettype wire

/* verilog/mini_core_accel_mul_farm.sv */
// Unsigned 8x8 only; a restart reuses the unit and the older result is never flagged done
`timescale 1ns/10ps
`default_nettype none

module mini_core_accel_mul_farm
    import mini_core_accel_pkg::*;
(
    input  logic        Clk,
    input  logic        rst_n,
    input  logic        mul_start        [NUM_MULS],
    input  logic [7:0]  mul_multiplicand [NUM_MULS],
    input  logic [7:0]  mul_multiplier   [NUM_MULS],
    output logic        mul_done         [NUM_MULS],
    output logic [15:0] mul_result       [NUM_MULS]
);

// Stage one operands
logic [7:0]             stage_a    [NUM_MULS];
logic [7:0]             stage_b    [NUM_MULS];

// Start travels alongside, top bit marks product stage
logic [MUL_LATENCY-2:0] start_pipe [NUM_MULS];

// --------------------------------------------------
// Stage one
// --------------------------------------------------
always_ff @(posedge Clk) begin
    for (int i = 0; i < NUM_MULS; i++) begin
        if (mul_start[i]) begin
            stage_a[i] <= mul_multiplicand[i];
            stage_b[i] <= mul_multiplier[i];
        end
    end
end

// --------------------------------------------------
// Stage two and done
// --------------------------------------------------
always_ff @(posedge Clk) begin
    if (!rst_n) begin
        for (int i = 0; i < NUM_MULS; i++) begin
            start_pipe[i] <= '0;
            mul_done[i]   <= 1'b0;
            mul_result[i] <= '0;
        end
    end else begin
        for (int i = 0; i < NUM_MULS; i++) begin
            start_pipe[i] <= (start_pipe[i] << 1) | (MUL_LATENCY - 1)'(mul_start[i]);
            if (start_pipe[i][MUL_LATENCY-2]) begin
                mul_result[i] <= 16'(stage_a[i]) * 16'(stage_b[i]);
            end
            // New start wins over a finishing item
            if (mul_start[i]) begin
                mul_done[i] <= 1'b0;
            end else if (start_pipe[i][MUL_LATENCY-2]) begin
                mul_done[i] <= 1'b1;
            end
        end
    end
end

endmodule

`default_nettype wire

/* verilog/mini_core_accel_cr_mem.sv */
// Only 32-bit word accesses; operand registers are write-only and unmapped reads give zero
`timescale 1ns/10ps
`default_nettype none

module mini_core_accel_cr_mem
    import mini_core_accel_pkg::*;
(
    input  logic        Clk,
    input  logic        rst_n,

    // CR access path
    input  logic        cr_wren,
    input  logic        cr_rden,
    input  logic [31:0] cr_addr,
    input  logic [31:0] cr_wdata,
    output logic [31:0] cr_q,

    // Multiplier farm
    input  logic        mul_done         [NUM_MULS],
    input  logic [15:0] mul_result       [NUM_MULS],
    output logic        mul_start        [NUM_MULS],
    output logic [7:0]  mul_multiplicand [NUM_MULS],
    output logic [7:0]  mul_multiplier   [NUM_MULS]
);

t_mul_operands        core2mul [NUM_MULS];
logic [16:0]          mul2core [NUM_MULS];
logic [MUL_IDX_W-1:0] reg_idx;
logic                 word_aligned;
logic                 core2mul_hit;
logic                 mul2core_hit;
logic [31:0]          rd_word;

// --------------------------------------------------
// Address decode
// --------------------------------------------------
assign reg_idx      = cr_addr[2 +: MUL_IDX_W];
assign word_aligned = (cr_addr[1:0] == 2'b00);

assign core2mul_hit = word_aligned &&
    (cr_addr[31:CR_REGION_LSB] == CR_CORE2MUL_BASE[31:CR_REGION_LSB]);
assign mul2core_hit = word_aligned &&
    (cr_addr[31:CR_REGION_LSB] == CR_MUL2CORE_BASE[31:CR_REGION_LSB]);

// --------------------------------------------------
// Operand registers and start pulses
// --------------------------------------------------
always_ff @(posedge Clk) begin
    if (!rst_n) begin
        for (int i = 0; i < NUM_MULS; i++) begin
            core2mul[i]  <= '0;
            mul_start[i] <= 1'b0;
        end
    end else begin
        // Start fires the cycle after the write lands
        for (int i = 0; i < NUM_MULS; i++) begin
            mul_start[i] <= cr_wren && core2mul_hit && (reg_idx == MUL_IDX_W'(i));
        end
        if (cr_wren && core2mul_hit) begin
            core2mul[reg_idx].raw <= cr_wdata[15:0];
        end
    end
end

always_comb begin
    for (int i = 0; i < NUM_MULS; i++) begin
        mul_multiplicand[i] = core2mul[i].ops.multiplicand;
        mul_multiplier[i]   = core2mul[i].ops.multiplier;
    end
end

// --------------------------------------------------
// Status registers, sampled every clock
// --------------------------------------------------
always_ff @(posedge Clk) begin
    for (int i = 0; i < NUM_MULS; i++) begin
        if (!rst_n) begin
            mul2core[i] <= '0;
        end else begin
            mul2core[i] <= {mul_done[i], mul_result[i]};
        end
    end
end

// Read mux, zero outside the status bank
always_comb begin
    rd_word = '0;
    if (mul2core_hit) begin
        rd_word = {15'b0, mul2core[reg_idx]};
    end
end

always_ff @(posedge Clk) begin
    if (!rst_n) begin
        cr_q <= '0;
    end else begin
        cr_q <= cr_rden ? rd_word : '0;
    end
end

endmodule

`default_nettype wire

/* verilog/mini_core_accel_cr_arb.sv */
// Masters must hold a credit for every req_valid cycle; queues have no overflow guard or ready
`timescale 1ns/10ps
`default_nettype none

module mini_core_accel_cr_arb
    import mini_core_accel_pkg::*;
(
    input  logic        Clk,
    input  logic        rst_n,

    // Master side, one entry per port
    input  logic        req_valid     [NUM_PORTS],
    input  logic        req_write     [NUM_PORTS],
    input  logic [31:0] req_addr      [NUM_PORTS],
    input  logic [31:0] req_wdata     [NUM_PORTS],
    output logic        credit_return [NUM_PORTS],
    output logic        rsp_valid     [NUM_PORTS],
    output logic [31:0] rsp_rdata     [NUM_PORTS],

    // Shared CR access path
    output logic        cr_wren,
    output logic        cr_rden,
    output logic [31:0] cr_addr,
    output logic [31:0] cr_wdata,
    input  logic [31:0] cr_q
);

// Request queues
logic                   q_write  [NUM_PORTS][NUM_CREDITS];
logic [31:0]            q_addr   [NUM_PORTS][NUM_CREDITS];
logic [31:0]            q_wdata  [NUM_PORTS][NUM_CREDITS];
logic [QUEUE_PTR_W-1:0] q_wr_ptr [NUM_PORTS];
logic [QUEUE_PTR_W-1:0] q_rd_ptr [NUM_PORTS];
logic [QUEUE_CNT_W-1:0] q_count  [NUM_PORTS];

// Grant and in-flight read
logic                   grant_valid;
logic [PORT_IDX_W-1:0]  cr_port;
logic [PORT_IDX_W-1:0]  rr_ptr;
logic                   rd_pending;
logic [PORT_IDX_W-1:0]  rd_port;

function automatic logic [QUEUE_PTR_W-1:0] next_ptr(input logic [QUEUE_PTR_W-1:0] ptr);
    return (ptr == QUEUE_PTR_W'(NUM_CREDITS - 1)) ? '0 : ptr + 1'b1;
endfunction

// --------------------------------------------------
// Queue storage and pointers
// --------------------------------------------------
always_ff @(posedge Clk) begin
    for (int p = 0; p < NUM_PORTS; p++) begin
        if (req_valid[p]) begin
            q_write[p][q_wr_ptr[p]] <= req_write[p];
            q_addr[p][q_wr_ptr[p]]  <= req_addr[p];
            q_wdata[p][q_wr_ptr[p]] <= req_wdata[p];
        end
    end
end

always_ff @(posedge Clk) begin
    if (!rst_n) begin
        for (int p = 0; p < NUM_PORTS; p++) begin
            q_wr_ptr[p] <= '0;
            q_rd_ptr[p] <= '0;
            q_count[p]  <= '0;
        end
    end else begin
        for (int p = 0; p < NUM_PORTS; p++) begin
            if (req_valid[p]) begin
                q_wr_ptr[p] <= next_ptr(q_wr_ptr[p]);
            end
            // A grant pops the head
            if (credit_return[p]) begin
                q_rd_ptr[p] <= next_ptr(q_rd_ptr[p]);
            end
            q_count[p] <= q_count[p] + QUEUE_CNT_W'(req_valid[p])
                                     - QUEUE_CNT_W'(credit_return[p]);
        end
    end
end

// --------------------------------------------------
// Round-robin grant
// --------------------------------------------------
always_comb begin
    int idx;
    grant_valid = 1'b0;
    cr_port     = '0;
    // First non-empty queue starting at rr_ptr
    for (int k = 0; k < NUM_PORTS; k++) begin
        idx = (int'(rr_ptr) + k) % NUM_PORTS;
        if (!grant_valid && q_count[idx] != '0) begin
            grant_valid = 1'b1;
            cr_port     = PORT_IDX_W'(idx);
        end
    end
end

always_comb begin
    for (int p = 0; p < NUM_PORTS; p++) begin
        credit_return[p] = grant_valid && (cr_port == PORT_IDX_W'(p));
    end
end

assign cr_wren  = grant_valid && q_write[cr_port][q_rd_ptr[cr_port]];
assign cr_rden  = grant_valid && !q_write[cr_port][q_rd_ptr[cr_port]];
assign cr_addr  = q_addr[cr_port][q_rd_ptr[cr_port]];
assign cr_wdata = q_wdata[cr_port][q_rd_ptr[cr_port]];

always_ff @(posedge Clk) begin
    if (!rst_n) begin
        rr_ptr     <= '0;
        rd_pending <= 1'b0;
        rd_port    <= '0;
    end else begin
        // Winner drops to lowest priority
        if (grant_valid) begin
            rr_ptr <= (cr_port == PORT_IDX_W'(NUM_PORTS - 1)) ? '0 : cr_port + 1'b1;
        end
        rd_pending <= cr_rden;
        rd_port    <= cr_port;
    end
end

// --------------------------------------------------
// Read response routing
// --------------------------------------------------
always_ff @(posedge Clk) begin
    for (int p = 0; p < NUM_PORTS; p++) begin
        if (!rst_n) begin
            rsp_valid[p] <= 1'b0;
        end else begin
            rsp_valid[p] <= rd_pending && (rd_port == PORT_IDX_W'(p));
        end
    end
end

always_ff @(posedge Clk) begin
    for (int p = 0; p < NUM_PORTS; p++) begin
        if (rd_pending && (rd_port == PORT_IDX_W'(p))) begin
            rsp_rdata[p] <= cr_q;
        end
    end
end

endmodule

`default_nettype wire

/* verilog/mini_core_accel_pkg.sv */
// Bank bases must stay aligned to NUM_MULS words and NUM_MULS a power of two; widths are fixed
`default_nettype none

package mini_core_accel_pkg;

    // --------------------------------------------------
    // Topology
    // --------------------------------------------------
    localparam int NUM_PORTS   = 2;
    localparam int NUM_MULS    = 8;
    localparam int NUM_CREDITS = 2;

    // Start to done, at least 2
    localparam int MUL_LATENCY = 2;

    // Index and counter widths
    localparam int PORT_IDX_W  = (NUM_PORTS > 1) ? $clog2(NUM_PORTS) : 1;
    localparam int QUEUE_PTR_W = (NUM_CREDITS > 1) ? $clog2(NUM_CREDITS) : 1;
    localparam int QUEUE_CNT_W = $clog2(NUM_CREDITS + 1);
    localparam int MUL_IDX_W   = $clog2(NUM_MULS);

    // --------------------------------------------------
    // Address map
    // --------------------------------------------------
    // Operand words, one per multiplier, word stride 4
    localparam logic [31:0] CR_CORE2MUL_BASE = 32'h0000_0000;

    // Status words {15'b0, done, result}, word stride 4
    localparam logic [31:0] CR_MUL2CORE_BASE = 32'h0000_0040;

    // Lowest address bit above the register index
    localparam int CR_REGION_LSB = MUL_IDX_W + 2;

    // --------------------------------------------------
    // Operand register
    // --------------------------------------------------
    // Loaded as raw from wdata[15:0], consumed by the farm as a pair
    typedef union packed {
        logic [15:0] raw;
        struct packed {
            logic [7:0] multiplicand;
            logic [7:0] multiplier;
        } ops;
    } t_mul_operands;

endpackage

`default_nettype wire
